// ==== logic/nocPkg.sv ====
package nocPkg;

  // Port count is fixed by the mesh, widths by the flit format
  localparam int numPorts    = 5;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;
  localparam int dataWidth   = 16;

  typedef logic [flitIdWidth-1:0] flitId_t;
  typedef logic [lengthWidth-1:0] length_t;    // Packet length, also hold budget in cycles
  typedef logic [dataWidth-1:0]   flitData_t;
  typedef logic [numPorts-1:0]    portMask_t;  // Bit 0 Local, then N, E, W, S

  localparam flitId_t flitIdHead = 3'd1;       // Header flit carries the length

  typedef enum logic [2:0]
  {
    idle,
    grantL,
    grantN,
    grantE,
    grantW,
    grantS
  } arbState_t;

endpackage

// ==== logic/laneIf.sv ====
`timescale 1ns/10ps

interface laneIf;

  logic              req;       // Level request from the input
  logic              timesUp;   // Hold budget spent
  logic              runTimer;  // Granted lane keeps counting
  logic              grant;
  logic              pending;   // Buffered flit waiting
  nocPkg::flitData_t flit;
  logic              taken;     // Mux drains the buffer this cycle

  modport arbiter
  (
    input  req,
    input  timesUp,
    output runTimer,
    output grant
  );

  modport mux
  (
    input  grant,
    input  pending,
    input  flit,
    output taken
  );

  modport lane
  (
    output req,
    output timesUp,
    input  runTimer,
    input  grant,
    output pending,
    output flit,
    input  taken
  );

endinterface

// ==== logic/portArbiter.sv ====
`timescale 1ns/10ps

module portArbiter
(
  input  logic              clk,
  input  logic              rst,
  laneIf.arbiter            lanes [nocPkg::numPorts],
  output nocPkg::portMask_t grant
);

  nocPkg::arbState_t curState;
  nocPkg::arbState_t nextState;
  nocPkg::portMask_t req;
  nocPkg::portMask_t timesUp;
  nocPkg::portMask_t runTimer;

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gLane
    assign req[i]            = lanes[i].req;
    assign timesUp[i]        = lanes[i].timesUp;
    assign lanes[i].grant    = grant[i];
    assign lanes[i].runTimer = runTimer[i];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      curState <= nocPkg::idle;
    else
      curState <= nextState;
  end

  // Rotating priority, the holder itself is searched last
  always_comb
  begin
    int curIdx;
    int idx;
    curIdx    = int'(curState) - 1;
    idx       = 0;
    nextState = curState;
    runTimer  = '0;
    if (curState == nocPkg::idle || curIdx >= nocPkg::numPorts)
    begin
      nextState = nocPkg::idle;
      for (int i = nocPkg::numPorts - 1; i >= 0; i--)
      begin
        if (req[i])
          nextState = nocPkg::arbState_t'(i + 1);  // Lowest index wins
      end
    end
    else if (req[curIdx] && !timesUp[curIdx])
    begin
      runTimer[curIdx] = 1'b1;                      // Holder keeps the port
    end
    else
    begin
      nextState = nocPkg::idle;
      for (int k = nocPkg::numPorts; k >= 1; k--)
      begin
        idx = (curIdx + k) % nocPkg::numPorts;
        if (req[idx])
          nextState = nocPkg::arbState_t'(idx + 1);  // Nearest follower wins
      end
    end
  end

  // One-hot grant from the registered state
  always_comb
  begin
    int curIdx;
    curIdx = int'(curState) - 1;
    grant  = '0;
    if (curState != nocPkg::idle && curIdx < nocPkg::numPorts)
      grant[curIdx] = 1'b1;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("grant is not one-hot: %b", grant);

  timerOnlyGranted: assert property (@(posedge clk) disable iff (rst)
    (runTimer & ~grant) == '0)
    else $error("runTimer %b outside grant %b", runTimer, grant);

  // A holder that stops requesting gives the port up at the next edge
  releaseOnDrop: assert property (@(posedge clk) disable iff (rst)
    (grant != '0 && (grant & req) == '0 && (req & ~grant) != '0) |=>
      (grant != $past(grant)))
    else $error("grant held without request");

endmodule

// ==== logic/inputLane.sv ====
`timescale 1ns/10ps

module inputLane
(
  input  logic              clk,
  input  logic              rst,
  input  logic              flitValid,
  input  nocPkg::flitId_t   flitId,
  input  nocPkg::length_t   flitLength,
  input  nocPkg::flitData_t flitData,
  laneIf.lane               lane
);

  logic              pending;
  nocPkg::flitData_t flitBuf;
  nocPkg::length_t   storedLength;
  nocPkg::length_t   count;

  // Control state and the budget
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pending      <= 1'b0;
      storedLength <= '0;
      count        <= '0;
    end
    else
    begin
      if (flitValid)
        pending <= 1'b1;                      // New strobe wins over a drain
      else if (lane.taken)
        pending <= 1'b0;

      if (flitValid && flitId == nocPkg::flitIdHead)
        storedLength <= flitLength;           // Only headers carry a length

      if (!lane.runTimer)
        count <= '0;
      else
        count <= count + 1'b1;
    end
  end

  // Payload buffer, overwritten on every strobe
  always_ff @(posedge clk)
  begin
    if (flitValid)
      flitBuf <= flitData;
  end

  assign lane.pending = pending;
  assign lane.flit    = flitBuf;
  assign lane.timesUp = (count == storedLength);

  takenNeedsPending: assert property (@(posedge clk) disable iff (rst)
    lane.taken |-> pending)
    else $error("taken without a pending flit");

  // Budget only advances while this lane holds the port
  countOnlyWhenGranted: assert property (@(posedge clk) disable iff (rst)
    lane.runTimer |-> lane.grant)
    else $error("hold timer running without grant");

endmodule

// ==== logic/outputMux.sv ====
`timescale 1ns/10ps

module outputMux
(
  input  logic               clk,
  input  logic               rst,
  laneIf.mux                 lanes [nocPkg::numPorts],
  output logic               outValid,
  output nocPkg::flitData_t  outFlit,
  output nocPkg::portMask_t  outPort
);

  nocPkg::portMask_t grant;
  nocPkg::portMask_t pending;
  nocPkg::portMask_t taken;
  nocPkg::flitData_t flits [nocPkg::numPorts];
  nocPkg::flitData_t selFlit;

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gLane
    assign grant[i]       = lanes[i].grant;
    assign pending[i]     = lanes[i].pending;
    assign flits[i]       = lanes[i].flit;
    assign lanes[i].taken = taken[i];
  end

  assign taken = grant & pending;  // Granted lane with a flit in hand

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (taken[i])
        selFlit = flits[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= '0;
    end
    else
    begin
      outValid <= |taken;
      outPort  <= grant;             // Follows the grant even with no flit
    end
  end

  always_ff @(posedge clk)
  begin
    if (|taken)
      outFlit <= selFlit;
  end

  takenOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(taken))
    else $error("more than one lane drained: %b", taken);

endmodule

// ==== logic/routerOutput.sv ====
`timescale 1ns/10ps

module routerOutput
(
  input  logic               clk,
  input  logic               rst,
  input  nocPkg::portMask_t  req,
  input  nocPkg::portMask_t  flitValid,
  input  nocPkg::flitId_t    flitId [nocPkg::numPorts],
  input  nocPkg::length_t    flitLength [nocPkg::numPorts],
  input  nocPkg::flitData_t  flitData [nocPkg::numPorts],
  output logic               outValid,
  output nocPkg::flitData_t  outFlit,
  output nocPkg::portMask_t  outPort
);

  laneIf lanes [nocPkg::numPorts] ();

  // Lanes in order L, N, E, W, S
  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gLane
    assign lanes[i].req = req[i];

    inputLane uLane
    (
      .clk        (clk),
      .rst        (rst),
      .flitValid  (flitValid[i]),
      .flitId     (flitId[i]),
      .flitLength (flitLength[i]),
      .flitData   (flitData[i]),
      .lane       (lanes[i])
    );
  end

  portArbiter uArbiter
  (
    .clk   (clk),
    .rst   (rst),
    .lanes (lanes),
    .grant ()
  );

  outputMux uMux
  (
    .clk      (clk),
    .rst      (rst),
    .lanes    (lanes),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

// ==== tb/routerOutputTb.sv ====
`timescale 1ns/10ps

module routerOutputTb;

  localparam int clkPeriod   = 20;
  localparam int testCycles  = 3 + 8 + 6 * 5 + 25 + 63 + 80 + 2;
  localparam int drainMargin = 120;  // Worst case drain plus slack

  logic                      clk;
  logic                      rst;
  nocPkg::portMask_t         req;
  nocPkg::portMask_t         flitValid;
  nocPkg::flitId_t           flitId [nocPkg::numPorts];
  nocPkg::length_t           flitLength [nocPkg::numPorts];
  nocPkg::flitData_t         flitData [nocPkg::numPorts];
  logic                      outValid;
  nocPkg::flitData_t         outFlit;
  nocPkg::portMask_t         outPort;

  // Reference model state
  int                        refGrant;  // -1 while idle
  nocPkg::length_t           refCount [nocPkg::numPorts];
  nocPkg::length_t           refLen [nocPkg::numPorts];
  nocPkg::flitData_t         refBuf [nocPkg::numPorts];
  nocPkg::portMask_t         refPending;
  logic                      expValid;
  nocPkg::flitData_t         expFlit;
  nocPkg::portMask_t         expPort;

  logic [31:0]               lfsrState;
  int                        errCount;
  int                        testCount;

  routerOutput i_dut
  (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .flitValid  (flitValid),
    .flitId     (flitId),
    .flitLength (flitLength),
    .flitData   (flitData),
    .outValid   (outValid),
    .outFlit    (outFlit),
    .outPort    (outPort)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expV,
                                input logic [31:0] gotV);
    errCount++;
    $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, expV, gotV);
  endtask

  // Arbitration and buffering as seen from the ports
  always @(posedge clk)
  begin : refModel
    int   nextGrant;
    int   start;
    int   idx;
    int   takenIdx;
    logic hold;
    if (rst)
    begin
      refGrant   <= -1;
      refPending <= '0;
      expValid   <= 1'b0;
      expPort    <= '0;
      expFlit    <= '0;
      for (int i = 0; i < nocPkg::numPorts; i++)
      begin
        refCount[i] <= '0;
        refLen[i]   <= '0;
      end
    end
    else
    begin
      hold = refGrant >= 0 && req[refGrant] && (refCount[refGrant] != refLen[refGrant]);
      nextGrant = refGrant;
      if (!hold)
      begin
        nextGrant = -1;
        start = (refGrant < 0) ? nocPkg::numPorts - 1 : refGrant;  // Idle searches from L
        for (int k = 1; k <= nocPkg::numPorts; k++)
        begin
          idx = (start + k) % nocPkg::numPorts;
          if (req[idx] && nextGrant < 0)
            nextGrant = idx;
        end
      end
      takenIdx = (refGrant >= 0 && refPending[refGrant]) ? refGrant : -1;
      expValid <= (takenIdx >= 0);
      expPort  <= (refGrant >= 0) ? (nocPkg::portMask_t'(1) << refGrant) : '0;
      if (takenIdx >= 0)
        expFlit <= refBuf[takenIdx];
      for (int i = 0; i < nocPkg::numPorts; i++)
      begin
        if (flitValid[i])
          refPending[i] <= 1'b1;
        else if (i == takenIdx)
          refPending[i] <= 1'b0;
        if (flitValid[i] && flitId[i] == nocPkg::flitIdHead)
          refLen[i] <= flitLength[i];
        if (flitValid[i])
          refBuf[i] <= flitData[i];
        refCount[i] <= (hold && i == refGrant) ? refCount[i] + 1'b1 : '0;
      end
      refGrant <= nextGrant;
    end
  end

  outValidMatch: assert property (@(posedge clk) disable iff (rst) outValid == expValid)
    else reportMismatch("outValid", 32'($sampled(expValid)), 32'($sampled(outValid)));

  outPortMatch: assert property (@(posedge clk) disable iff (rst) outPort == expPort)
    else reportMismatch("outPort", 32'($sampled(expPort)), 32'($sampled(outPort)));

  outFlitMatch: assert property (@(posedge clk) disable iff (rst)
    outValid |-> outFlit == expFlit)
    else reportMismatch("outFlit", 32'($sampled(expFlit)), 32'($sampled(outFlit)));

  // One clock of stimulus that never strobes a pending lane
  task automatic driveCycle(input nocPkg::portMask_t reqMask,
                            input nocPkg::portMask_t strobeMask,
                            input logic forceHead, input int lenBits);
    @(negedge clk);
    req = reqMask;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      flitValid[i] = strobeMask[i] && !refPending[i];
      if (flitValid[i])
      begin
        flitId[i]     = forceHead ? nocPkg::flitIdHead : nocPkg::flitId_t'(randBits(3));
        flitLength[i] = nocPkg::length_t'(randBits(lenBits));
        flitData[i]   = nocPkg::flitData_t'(randBits(16));
      end
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testCount++;
    $display("Test %s finished with %0d mismatches", name, errCount - errBefore);
  endtask

  initial
  begin
    int                errBefore;
    nocPkg::portMask_t mask;
    clk       = 1'b0;
    rst       = 1'b1;
    req       = '0;
    flitValid = '0;
    lfsrState = 32'h434c1e8c;
    errCount  = 0;
    testCount = 0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      flitId[i]     = '0;
      flitLength[i] = '0;
      flitData[i]   = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    errBefore = errCount;
    repeat (8) driveCycle('0, '0, 1'b0, 0);
    finishTest("idleAfterReset", errBefore);

    errBefore = errCount;
    repeat (6)
    begin
      mask = nocPkg::portMask_t'(randBits(5));
      if (mask == '0)
        mask = 5'b10000;
      repeat (3) driveCycle(mask, '0, 1'b0, 0);
      repeat (2) driveCycle('0, '0, 1'b0, 0);  // Back to idle
    end
    finishTest("firstRequester", errBefore);

    errBefore = errCount;
    repeat (25) driveCycle('1, '0, 1'b0, 0);
    finishTest("rotation", errBefore);

    errBefore = errCount;
    driveCycle('0, '1, 1'b1, 3);  // Headers with budgets 0 to 7
    repeat (2) driveCycle('0, '0, 1'b0, 0);
    repeat (60) driveCycle('1, '0, 1'b0, 0);
    finishTest("holdBudget", errBefore);

    errBefore = errCount;
    repeat (80)
      driveCycle(nocPkg::portMask_t'(randBits(5)), nocPkg::portMask_t'(randBits(5)), 1'b0, 2);
    while (refPending != '0)
      driveCycle('1, '0, 1'b0, 0);
    repeat (2) driveCycle('0, '0, 1'b0, 0);
    finishTest("flitDelivery", errBefore);

    $display("Tests run: %0d, mismatches: %0d", testCount, errCount);
    if (errCount == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    #((testCycles + drainMargin) * clkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not complete",
             testCycles + drainMargin);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== routerOutput.f ====
logic/nocPkg.sv
logic/laneIf.sv
logic/portArbiter.sv
logic/inputLane.sv
logic/outputMux.sv
logic/routerOutput.sv
tb/routerOutputTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the routerOutput testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
simExe=simRouterOutput

verilator --binary --timing --assert -Wno-fatal \
  -f routerOutput.f \
  --top-module routerOutputTb \
  --Mdir "$buildDir" \
  -o "$simExe"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

"./$buildDir/$simExe" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$logFile"; then
  echo "Testbench reported failure, see $logFile"
  exit 1
fi

if ! grep -q "Simulation finished: PASS" "$logFile"; then
  echo "No verdict found in $logFile"
  exit 1
fi

exit 0
